// ==== pager_pkg.sv ====
package pager_pkg;

  // address geometry
  localparam int VADDR_WIDTH = 32;
  localparam int PADDR_WIDTH = 32;
  localparam int PAGE_SHIFT  = 12;
  localparam int LEVEL_BITS  = 10;
  localparam int VPN_WIDTH   = VADDR_WIDTH - PAGE_SHIFT;
  localparam int PPN_WIDTH   = PADDR_WIDTH - PAGE_SHIFT;

  // page-table entry layout, next ppn sits in the top bits
  localparam int PTE_WIDTH   = 32;
  localparam int PTE_PRESENT = 0;
  localparam int PTE_WRITE   = 1;
  localparam int PTE_USER    = 2;

  // fill flags keep the pte bit order
  localparam int FLAG_WIDTH  = 3;

  localparam int SLOT_COUNT  = 3;

  // memory tag carries the slot number
  localparam int TAG_WIDTH   = 2;

  // csr numbers seen on the write port
  typedef enum logic [3:0] {
    CSR_PAGE_ROOT = 4'h1,
    CSR_PAGE_OFF  = 4'h2
  } csr_no_e;

  // walker slot states
  typedef enum logic [2:0] {
    IDLE,
    L1_REQ,
    L1_WAIT,
    L2_REQ,
    L2_WAIT,
    FILL
  } walk_state_e;

endpackage

// ==== pager_csr.sv ====
`timescale 1ns/1ps

module pager_csr import pager_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 csr_en,
  input  csr_no_e              csr_no,
  input  logic [PPN_WIDTH-1:0] csr_data,
  output logic                 paging_on,
  output logic [PPN_WIDTH-1:0] root_ppn,
  output logic                 walk_flush
);

  always_ff @(posedge clk) begin
    if (rst) begin
      paging_on <= 1'b0;
      root_ppn  <= '0;
    end else if (csr_en) begin
      case (csr_no)
        CSR_PAGE_ROOT: begin
          root_ppn  <= csr_data;
          paging_on <= 1'b1;
        end
        CSR_PAGE_OFF: begin
          paging_on <= 1'b0;
        end
        default: begin
          // unknown numbers leave both registers unchanged
        end
      endcase
    end
  end

  // any write restarts the walkers on the following edge
  always_ff @(posedge clk) begin
    if (rst) begin
      walk_flush <= 1'b0;
    end else begin
      walk_flush <= csr_en;
    end
  end

endmodule

// ==== page_walker.sv ====
`timescale 1ns/1ps

module page_walker import pager_pkg::*; #(
  parameter int SLOT = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   new_valid,
  output logic                   new_ready,
  input  logic [VADDR_WIDTH-1:0] new_vaddr,
  input  logic                   paging_on,
  input  logic [PPN_WIDTH-1:0]   root_ppn,
  input  logic                   walk_flush,
  output logic                   walk_req,
  output logic [PADDR_WIDTH-1:0] walk_addr,
  input  logic                   walk_grant,
  input  logic                   mem_rsp_valid,
  input  logic [TAG_WIDTH-1:0]   mem_rsp_tag,
  input  logic [PTE_WIDTH-1:0]   mem_rsp_data,
  output logic                   fill_valid,
  output logic [VPN_WIDTH-1:0]   fill_vpn,
  output logic [PPN_WIDTH-1:0]   fill_ppn,
  output logic [FLAG_WIDTH-1:0]  fill_flags,
  output logic                   fill_fault
);

  localparam logic [TAG_WIDTH-1:0] SLOT_TAG = TAG_WIDTH'(SLOT);

  walk_state_e state;

  logic [VADDR_WIDTH-1:0] vaddr_q;
  logic [PPN_WIDTH-1:0]   ppn_q;
  logic [FLAG_WIDTH-1:0]  flags_q;
  logic                   fault_q;

  logic                   accept;
  logic                   rsp_hit;
  logic                   pte_present;
  logic [PPN_WIDTH-1:0]   pte_ppn;
  logic [FLAG_WIDTH-1:0]  pte_flags;
  logic [PPN_WIDTH-1:0]   base_ppn;
  logic [LEVEL_BITS-1:0]  level_idx;

  assign new_ready = (state == IDLE);
  assign accept    = new_valid && new_ready;

  // only responses carrying our own slot number
  assign rsp_hit = mem_rsp_valid && (mem_rsp_tag == SLOT_TAG);

  assign pte_present = mem_rsp_data[PTE_PRESENT];
  assign pte_ppn     = mem_rsp_data[PTE_WIDTH-1:PAGE_SHIFT];
  assign pte_flags   = {mem_rsp_data[PTE_USER], mem_rsp_data[PTE_WRITE],
                        mem_rsp_data[PTE_PRESENT]};

  // level 1 indexes the root table with the top bits, level 2 uses the middle bits
  always_comb begin
    if (state == L2_REQ) begin
      base_ppn  = ppn_q;
      level_idx = vaddr_q[PAGE_SHIFT +: LEVEL_BITS];
    end else begin
      base_ppn  = root_ppn;
      level_idx = vaddr_q[VADDR_WIDTH-1 -: LEVEL_BITS];
    end
  end

  assign walk_req  = (state == L1_REQ) || (state == L2_REQ);
  assign walk_addr = {base_ppn, {PAGE_SHIFT{1'b0}}}
                   + {{(PADDR_WIDTH-LEVEL_BITS-2){1'b0}}, level_idx, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= 1'b0;
      if (walk_flush && state != IDLE) begin
        // abandon the walk, no fill
        state <= IDLE;
      end else begin
        case (state)
          IDLE: begin
            if (accept) begin
              state <= paging_on ? L1_REQ : FILL;
            end
          end
          L1_REQ: begin
            if (walk_grant) begin
              state <= L1_WAIT;
            end
          end
          L1_WAIT: begin
            if (rsp_hit) begin
              state <= pte_present ? L2_REQ : FILL;
            end
          end
          L2_REQ: begin
            if (walk_grant) begin
              state <= L2_WAIT;
            end
          end
          L2_WAIT: begin
            if (rsp_hit) begin
              state <= FILL;
            end
          end
          FILL: begin
            state      <= IDLE;
            fill_valid <= 1'b1;
          end
          default: begin
            state <= IDLE;
          end
        endcase
      end
    end
  end

  // translation result, flags narrowed level by level
  always_ff @(posedge clk) begin
    if (accept) begin
      vaddr_q <= new_vaddr;
      flags_q <= '1;
      fault_q <= 1'b0;
      if (!paging_on) begin
        ppn_q <= new_vaddr[VADDR_WIDTH-1:PAGE_SHIFT];
      end
    end else if (rsp_hit && (state == L1_WAIT || state == L2_WAIT)) begin
      if (pte_present) begin
        ppn_q   <= pte_ppn;
        flags_q <= flags_q & pte_flags;
      end else begin
        ppn_q   <= '0;
        flags_q <= '0;
        fault_q <= 1'b1;
      end
    end
  end

  // held until the next accept, which cannot come before the pulse ends
  assign fill_vpn   = vaddr_q[VADDR_WIDTH-1:PAGE_SHIFT];
  assign fill_ppn   = ppn_q;
  assign fill_flags = flags_q;
  assign fill_fault = fault_q;

endmodule

// ==== mem_req_arbiter.sv ====
`timescale 1ns/1ps

module mem_req_arbiter import pager_pkg::*; #(
  parameter int SLOT_COUNT = pager_pkg::SLOT_COUNT
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [SLOT_COUNT-1:0]                 walk_req,
  input  logic [SLOT_COUNT-1:0][PADDR_WIDTH-1:0] walk_addr,
  input  logic                                  bus_hold,
  output logic [SLOT_COUNT-1:0]                 walk_grant,
  output logic                                  mem_req_valid,
  output logic [PADDR_WIDTH-1:0]                mem_req_addr,
  output logic [TAG_WIDTH-1:0]                  mem_req_tag
);

  logic [TAG_WIDTH-1:0] sel;
  logic                 found;

  // lowest slot wins, nothing granted while the bus is held
  always_comb begin
    walk_grant = '0;
    sel        = '0;
    found      = 1'b0;
    for (int i = 0; i < SLOT_COUNT; i++) begin
      if (walk_req[i] && !found && !bus_hold) begin
        walk_grant[i] = 1'b1;
        sel           = TAG_WIDTH'(i);
        found         = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_valid <= 1'b0;
    end else begin
      mem_req_valid <= found;
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      mem_req_addr <= walk_addr[sel];
      mem_req_tag  <= sel;
    end
  end

endmodule

// ==== pager_top.sv ====
`timescale 1ns/1ps

module pager_top import pager_pkg::*; #(
  parameter int SLOT_COUNT = pager_pkg::SLOT_COUNT
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   csr_en,
  input  csr_no_e                                csr_no,
  input  logic [PPN_WIDTH-1:0]                   csr_data,
  input  logic                                   bus_hold,
  input  logic [SLOT_COUNT-1:0]                  new_valid,
  output logic [SLOT_COUNT-1:0]                  new_ready,
  input  logic [SLOT_COUNT-1:0][VADDR_WIDTH-1:0] new_vaddr,
  output logic [SLOT_COUNT-1:0]                  fill_valid,
  output logic [SLOT_COUNT-1:0][VPN_WIDTH-1:0]   fill_vpn,
  output logic [SLOT_COUNT-1:0][PPN_WIDTH-1:0]   fill_ppn,
  output logic [SLOT_COUNT-1:0][FLAG_WIDTH-1:0]  fill_flags,
  output logic [SLOT_COUNT-1:0]                  fill_fault,
  output logic                                   mem_req_valid,
  output logic [PADDR_WIDTH-1:0]                 mem_req_addr,
  output logic [TAG_WIDTH-1:0]                   mem_req_tag,
  input  logic                                   mem_rsp_valid,
  input  logic [TAG_WIDTH-1:0]                   mem_rsp_tag,
  input  logic [PTE_WIDTH-1:0]                   mem_rsp_data
);

  logic                                  paging_on;
  logic [PPN_WIDTH-1:0]                  root_ppn;
  logic                                  walk_flush;
  logic [SLOT_COUNT-1:0]                 walk_req;
  logic [SLOT_COUNT-1:0][PADDR_WIDTH-1:0] walk_addr;
  logic [SLOT_COUNT-1:0]                 walk_grant;

  pager_csr i_csr (
    .clk        (clk),
    .rst        (rst),
    .csr_en     (csr_en),
    .csr_no     (csr_no),
    .csr_data   (csr_data),
    .paging_on  (paging_on),
    .root_ppn   (root_ppn),
    .walk_flush (walk_flush)
  );

  // one walker per requester, responses broadcast to all
  for (genvar s = 0; s < SLOT_COUNT; s++) begin : walker_gen
    page_walker #(
      .SLOT (s)
    ) i_walker (
      .clk           (clk),
      .rst           (rst),
      .new_valid     (new_valid[s]),
      .new_ready     (new_ready[s]),
      .new_vaddr     (new_vaddr[s]),
      .paging_on     (paging_on),
      .root_ppn      (root_ppn),
      .walk_flush    (walk_flush),
      .walk_req      (walk_req[s]),
      .walk_addr     (walk_addr[s]),
      .walk_grant    (walk_grant[s]),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_tag   (mem_rsp_tag),
      .mem_rsp_data  (mem_rsp_data),
      .fill_valid    (fill_valid[s]),
      .fill_vpn      (fill_vpn[s]),
      .fill_ppn      (fill_ppn[s]),
      .fill_flags    (fill_flags[s]),
      .fill_fault    (fill_fault[s])
    );
  end

  mem_req_arbiter #(
    .SLOT_COUNT (SLOT_COUNT)
  ) i_arbiter (
    .clk           (clk),
    .rst           (rst),
    .walk_req      (walk_req),
    .walk_addr     (walk_addr),
    .bus_hold      (bus_hold),
    .walk_grant    (walk_grant),
    .mem_req_valid (mem_req_valid),
    .mem_req_addr  (mem_req_addr),
    .mem_req_tag   (mem_req_tag)
  );

endmodule

// ==== tb_page_mem.sv ====
`timescale 1ns/1ps

module tb_page_mem import pager_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mem_req_valid,
  input  logic [PADDR_WIDTH-1:0] mem_req_addr,
  input  logic [TAG_WIDTH-1:0]   mem_req_tag,
  input  logic [3:0]             rsp_delay,
  output logic                   mem_rsp_valid,
  output logic [TAG_WIDTH-1:0]   mem_rsp_tag,
  output logic [PTE_WIDTH-1:0]   mem_rsp_data
);

  // 64 KB of page tables, sixteen 4 KB pages
  logic [PTE_WIDTH-1:0] table_mem [0:16383];

  int unsigned          cycle;
  int unsigned          due_q[$];
  logic [TAG_WIDTH-1:0] tag_q[$];
  logic [PTE_WIDTH-1:0] data_q[$];

  initial begin
    mem_rsp_valid = 1'b0;
    mem_rsp_tag   = '0;
    mem_rsp_data  = '0;
    cycle         = 0;
  end

  always @(posedge clk) begin
    int hit;
    hit = -1;
    mem_rsp_valid <= 1'b0;
    if (rst) begin
      due_q.delete();
      tag_q.delete();
      data_q.delete();
    end else begin
      // oldest read whose delay has run out goes first
      for (int i = 0; i < due_q.size(); i++) begin
        if (hit < 0 && due_q[i] <= cycle) begin
          hit = i;
        end
      end
      if (hit >= 0) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_tag   <= tag_q[hit];
        mem_rsp_data  <= data_q[hit];
        due_q.delete(hit);
        tag_q.delete(hit);
        data_q.delete(hit);
      end
      if (mem_req_valid) begin
        due_q.push_back(cycle + 32'(rsp_delay));
        tag_q.push_back(mem_req_tag);
        data_q.push_back(table_mem[mem_req_addr[15:2]]);
      end
    end
    cycle = cycle + 1;
  end

endmodule

// ==== pager_props.sv ====
`timescale 1ns/1ps

module pager_props #(
  parameter int SLOT_COUNT = 3
) (
  input logic                  clk,
  input logic                  rst,
  input logic                  bus_hold,
  input logic                  mem_req_valid,
  input logic [SLOT_COUNT-1:0] walk_grant,
  input logic [SLOT_COUNT-1:0] fill_valid,
  input logic [SLOT_COUNT-1:0] new_ready
);

  // a held bus makes no grant, so no request the cycle after
  hold_blocks_req: assert property (@(posedge clk) disable iff (rst)
    $past(bus_hold) |-> !mem_req_valid)
    else $error("memory request issued after a bus_hold cycle");

  grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(walk_grant))
    else $error("walk_grant has more than one bit set");

  fill_single_pulse: assert property (@(posedge clk) disable iff (rst)
    (fill_valid & $past(fill_valid)) == '0)
    else $error("fill_valid stayed high for two cycles");

  ready_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> &new_ready)
    else $error("new_ready low right after reset");

endmodule

bind pager_top pager_props #(.SLOT_COUNT(SLOT_COUNT)) i_props (.*);

// ==== tb_pager.sv ====
`timescale 1ns/1ps

module tb_pager import pager_pkg::*; ();

  localparam int WALK_COUNT = 70;

  logic                                  clk;
  logic                                  rst;
  logic                                  csr_en;
  csr_no_e                               csr_no;
  logic [PPN_WIDTH-1:0]                  csr_data;
  logic                                  bus_hold;
  logic [SLOT_COUNT-1:0]                 new_valid;
  logic [SLOT_COUNT-1:0]                 new_ready;
  logic [SLOT_COUNT-1:0][VADDR_WIDTH-1:0] new_vaddr;
  logic [SLOT_COUNT-1:0]                 fill_valid;
  logic [SLOT_COUNT-1:0][VPN_WIDTH-1:0]  fill_vpn;
  logic [SLOT_COUNT-1:0][PPN_WIDTH-1:0]  fill_ppn;
  logic [SLOT_COUNT-1:0][FLAG_WIDTH-1:0] fill_flags;
  logic [SLOT_COUNT-1:0]                 fill_fault;
  logic                                  mem_req_valid;
  logic [PADDR_WIDTH-1:0]                mem_req_addr;
  logic [TAG_WIDTH-1:0]                  mem_req_tag;
  logic                                  mem_rsp_valid;
  logic [TAG_WIDTH-1:0]                  mem_rsp_tag;
  logic [PTE_WIDTH-1:0]                  mem_rsp_data;
  logic [3:0]                            rsp_delay;

  logic [15:0] lfsr_state;
  logic        hold_mode;
  logic        prev_hold;
  logic [19:0] cur_root;
  logic        cur_paging;
  string       test_name;
  int          err_count;
  int          test_err;
  int          fill_total;
  int          test_fills;
  int          test_count;
  int unsigned cycle_no;
  int          fills_seen [SLOT_COUNT];
  int          req_count [SLOT_COUNT];
  int unsigned accept_cycle [SLOT_COUNT];
  logic [25:0] exp_res [SLOT_COUNT];
  logic [19:0] exp_vpn [SLOT_COUNT];
  logic [31:0] exp_addr [SLOT_COUNT][2];

  pager_top #(.SLOT_COUNT(SLOT_COUNT)) i_dut (.*);

  tb_page_mem i_mem (
    .clk           (clk),
    .rst           (rst),
    .mem_req_valid (mem_req_valid),
    .mem_req_addr  (mem_req_addr),
    .mem_req_tag   (mem_req_tag),
    .rsp_delay     (rsp_delay),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_tag   (mem_rsp_tag),
    .mem_rsp_data  (mem_rsp_data)
  );

  always #4 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // word address of a pte from its table page and level index
  function automatic logic [31:0] pte_addr(input logic [19:0] base,
                                           input logic [9:0]  idx);
    return {base, 12'h000} + {20'h0, idx, 2'b00};
  endfunction

  // result packed as {depth, fault, flags, ppn}
  function automatic logic [25:0] ref_translate(input logic [31:0] va,
                                                input logic [19:0] root,
                                                input logic        on);
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] p1;
    logic [31:0] p2;
    if (!on) begin
      return {2'd0, 1'b0, 3'b111, va[31:12]};
    end
    a1 = pte_addr(root, va[31:22]);
    p1 = i_mem.table_mem[a1[15:2]];
    if (!p1[0]) begin
      return {2'd1, 1'b1, 3'b000, 20'h0};
    end
    a2 = pte_addr(p1[31:12], va[21:12]);
    p2 = i_mem.table_mem[a2[15:2]];
    if (!p2[0]) begin
      return {2'd2, 1'b1, 3'b000, 20'h0};
    end
    return {2'd2, 1'b0, p1[2] & p2[2], p1[1] & p2[1], 1'b1, p2[31:12]};
  endfunction

  task automatic check_value(input int s, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("** Error %s slot %0d %s: expected %h actual %h",
               test_name, s, what, exp, act);
      err_count++;
      test_err++;
    end
  endtask

  // compare every read address and fill with the reference taken at accept time
  always @(posedge clk) begin
    logic [31:0] l1_pte;
    cycle_no++;
    if (!rst) begin
      if (mem_req_valid) begin
        if (req_count[mem_req_tag] < 2) begin
          check_value(int'(mem_req_tag), "read addr",
                      exp_addr[mem_req_tag][req_count[mem_req_tag]], mem_req_addr);
        end
        req_count[mem_req_tag]++;
        assert (!prev_hold) else begin
          $display("%s: memory request issued right after bus_hold was high", test_name);
          err_count++;
          test_err++;
        end
      end
      for (int s = 0; s < SLOT_COUNT; s++) begin
        if (new_valid[s] && new_ready[s]) begin
          exp_res[s]      = ref_translate(new_vaddr[s], cur_root, cur_paging);
          exp_vpn[s]      = new_vaddr[s][31:12];
          exp_addr[s][0]  = pte_addr(cur_root, new_vaddr[s][31:22]);
          l1_pte          = i_mem.table_mem[exp_addr[s][0][15:2]];
          exp_addr[s][1]  = pte_addr(l1_pte[31:12], new_vaddr[s][21:12]);
          accept_cycle[s] = cycle_no;
          req_count[s]    = 0;
        end
        if (fill_valid[s]) begin
          check_value(s, "vpn", 32'(exp_vpn[s]), 32'(fill_vpn[s]));
          check_value(s, "ppn", 32'(exp_res[s][19:0]), 32'(fill_ppn[s]));
          check_value(s, "flags", 32'(exp_res[s][22:20]), 32'(fill_flags[s]));
          check_value(s, "fault", 32'(exp_res[s][23]), 32'(fill_fault[s]));
          check_value(s, "reads", 32'(exp_res[s][25:24]), 32'(req_count[s]));
          if (exp_res[s][25:24] == 2'd0) begin
            check_value(s, "latency", 32'd2, cycle_no - accept_cycle[s]);
          end
          fills_seen[s]++;
          test_fills++;
          fill_total++;
        end
      end
    end
    prev_hold = bus_hold;
  end

  // response delays and bus_hold pattern
  always @(posedge clk) begin
    rsp_delay <= 4'(32'd1 + rand_bits(3));
    bus_hold  <= hold_mode && (rand_bits(2) != 0);
  end

  // kind 0 any, 1 l1 fault, 2 l2 fault, 3 no fault
  task automatic pick_vaddr(input int kind, output logic [31:0] va);
    logic [25:0] r;
    for (int i = 0; i < 2000; i++) begin
      va = rand_bits(32);
      r  = ref_translate(va, cur_root, cur_paging);
      if (kind == 0 || (kind == 1 && r[25:23] == 3'b011) ||
          (kind == 2 && r[25:23] == 3'b101) || (kind == 3 && !r[23])) begin
        return;
      end
    end
    $display("%s: no address of kind %0d found in the page tables", test_name, kind);
    err_count++;
    test_err++;
  endtask

  task automatic translate(input int s, input logic [31:0] va);
    int target;
    target = fills_seen[s] + 1;
    @(posedge clk);
    new_valid[s] <= 1'b1;
    new_vaddr[s] <= va;
    @(posedge clk);
    while (!new_ready[s]) @(posedge clk);
    new_valid[s] <= 1'b0;
    while (fills_seen[s] < target) @(posedge clk);
  endtask

  task automatic run_slot(input int s, input int n, input int kind);
    logic [31:0] va;
    repeat (n) begin
      pick_vaddr(kind, va);
      translate(s, va);
    end
  endtask

  task automatic csr_write(input csr_no_e no, input logic [19:0] data);
    @(posedge clk);
    csr_en   <= 1'b1;
    csr_no   <= no;
    csr_data <= data;
    @(posedge clk);
    csr_en <= 1'b0;
    repeat (2) @(posedge clk);
    if (no == CSR_PAGE_ROOT) begin
      cur_root   = data;
      cur_paging = 1'b1;
    end else begin
      cur_paging = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_err   = 0;
    test_fills = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d fills checked, %0d errors", test_name, test_fills, test_err);
    test_count++;
  endtask

  initial begin
    logic [19:0] pp;
    clk        = 1'b0;
    rst        = 1'b1;
    csr_en     = 1'b0;
    csr_no     = CSR_PAGE_OFF;
    csr_data   = '0;
    bus_hold   = 1'b0;
    new_valid  = '0;
    new_vaddr  = '0;
    rsp_delay  = 4'd1;
    lfsr_state = 16'd3527;
    hold_mode  = 1'b0;
    prev_hold  = 1'b0;
    cur_root   = '0;
    cur_paging = 1'b0;
    err_count  = 0;
    fill_total = 0;
    test_count = 0;
    cycle_no   = 0;
    test_name  = "reset";
    for (int s = 0; s < SLOT_COUNT; s++) begin
      fills_seen[s] = 0;
      req_count[s]  = 0;
    end
    // next ppn stays inside the sixteen table pages
    for (int w = 0; w < 16384; w++) begin
      pp = 20'((w * 7 + 3) % 14 + 2);
      i_mem.table_mem[w] = {pp, 9'h0, rand_bits(1) != 0, rand_bits(1) != 0,
                            rand_bits(2) != 0};
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    start_test("identity");
    for (int s = 0; s < SLOT_COUNT; s++) begin
      run_slot(s, 2, 0);
    end
    end_test();

    start_test("walk_present");
    csr_write(CSR_PAGE_ROOT, 20'd1);
    for (int s = 0; s < SLOT_COUNT; s++) begin
      run_slot(s, 4, 3);
    end
    end_test();

    start_test("faults");
    run_slot(0, 1, 1);
    run_slot(0, 1, 2);
    run_slot(2, 1, 1);
    run_slot(2, 1, 2);
    end_test();

    start_test("concurrent");
    fork
      run_slot(0, 6, 0);
      run_slot(1, 6, 0);
      run_slot(2, 6, 0);
    join
    end_test();

    start_test("bus_hold");
    hold_mode = 1'b1;
    fork
      run_slot(0, 6, 0);
      run_slot(1, 6, 0);
      run_slot(2, 6, 0);
    join
    hold_mode = 1'b0;
    end_test();

    start_test("csr_root");
    csr_write(CSR_PAGE_ROOT, 20'd9);
    for (int s = 0; s < SLOT_COUNT; s++) begin
      run_slot(s, 2, 0);
    end
    csr_write(CSR_PAGE_OFF, 20'd0);
    for (int s = 0; s < SLOT_COUNT; s++) begin
      run_slot(s, 2, 0);
    end
    end_test();

    $display("%0d tests, %0d fills checked, %0d errors", test_count, fill_total, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // run limit of 200 cycles per walk
  initial begin
    #(WALK_COUNT * 200 * 8);
    $display("timeout: the walks did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== sources.f ====
pager_pkg.sv
pager_csr.sv
page_walker.sv
mem_req_arbiter.sv
pager_top.sv
tb_page_mem.sv
pager_props.sv
tb_pager.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pager -f sources.f

obj_dir/Vtb_pager > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  exit 1
fi
exit 0
